//--- flist.f
verilog/ladybird_pkg.sv
verilog/ladybird_alu.sv
verilog/ladybird_decode.sv
verilog/ladybird_lsu.sv
verilog/ladybird_core.sv
verilog/ladybird_top.sv
verification/ladybird_apb_mem.sv
verification/ladybird_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module ladybird_tb -f flist.f -o ladybird_sim \
  && ./obj_dir/ladybird_sim | tee /dev/stderr | grep -q "^TESTS PASSED$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation did not pass"; exit 1; }

//--- verification/ladybird_apb_mem.sv
module ladybird_apb_mem #(
  parameter int SEED = 15
) (
  input  logic                   clk,
  input  logic                   anrst,
  input  ladybird_pkg::apb_req_t i_req,
  output ladybird_pkg::apb_rsp_t o_rsp
);
  timeunit 1ns;
  timeprecision 1ps;
  import ladybird_pkg::*;

  localparam int WORDS = 256;

  word_t      mem [WORDS];
  word_t      fill_addr;
  int         seed;
  int         wait_left;
  logic       ready_n;
  logic [7:0] idx;

  initial begin
    seed      = SEED;
    wait_left = 0;
    o_rsp     = '0;
    for (int i = 0; i < WORDS; i++) begin
      fill_addr = i * 4;
      mem[i]    = {~fill_addr[15:0], fill_addr[15:0]}; // Unique per address
    end
  end

  // Response changes 1 ns after the edge
  always @(posedge clk) begin
    idx     = i_req.paddr[9:2];
    ready_n = 1'b0;
    if (i_req.psel && i_req.penable && o_rsp.pready && i_req.pwrite) begin
      for (int b = 0; b < 4; b++) begin
        if (i_req.pstrb[b]) begin
          mem[idx][8*b +: 8] = i_req.pwdata[8*b +: 8];
        end
      end
    end
    if (anrst && i_req.psel && !i_req.penable) begin
      wait_left = $random(seed) & 3; // 0 to 3 wait cycles
      ready_n   = (wait_left == 0);
    end else if (i_req.psel && i_req.penable && !o_rsp.pready) begin
      wait_left = wait_left - 1;
      ready_n   = (wait_left == 0);
    end
    #1;
    o_rsp.pready = ready_n;
    o_rsp.prdata = ready_n ? mem[idx] : '0;
  end

endmodule

//--- verification/ladybird_tb.sv
module ladybird_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ladybird_pkg::*;

  localparam int    MAX_CYCLES = 2000; // Twice 65 instructions at up to 14 cycles
  localparam word_t MARKER     = 32'h0000_03FC;

  logic     clk;
  logic     anrst;
  apb_req_t iapb, dapb;
  apb_rsp_t irsp, drsp;

  word_t      st_addr [32];
  word_t      st_data [32];
  word_t      st_mask [32];
  logic [3:0] st_strb [32];
  word_t      fetch_pc [80];
  int         nst, nfetch, sidx, fidx, cycles;
  int         proto_errs, value_errs, other_errs;
  logic       marker_seen;
  logic       f_setup, d_wr_done;

  ladybird_top u_dut (
    .clk    (clk),
    .anrst  (anrst),
    .o_iapb (iapb),
    .i_iapb (irsp),
    .o_dapb (dapb),
    .i_dapb (drsp)
  );

  ladybird_apb_mem u_imem (.clk(clk), .anrst(anrst), .i_req(iapb), .o_rsp(irsp));
  ladybird_apb_mem u_dmem (.clk(clk), .anrst(anrst), .i_req(dapb), .o_rsp(drsp));

  assign f_setup   = iapb.psel && !iapb.penable;
  assign d_wr_done = dapb.psel && dapb.penable && dapb.pwrite && drsp.pready;

  function automatic word_t rtype(input int f7, input int rs2, input int rs1, input int f3,
                                  input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic word_t itype(input int imm, input int rs1, input int f3, input int rd,
                                  input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic word_t stype(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t btype(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t utype(input int imm, input int rd, input logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic word_t jtype(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  task automatic put(input int pc, input word_t w);
    u_imem.mem[pc/4] = w;
  endtask

  task automatic expect_store(input word_t addr, input word_t data, input logic [3:0] strb);
    st_addr[nst] = addr;
    st_data[nst] = data;
    st_strb[nst] = strb;
    st_mask[nst] = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    nst++;
  endtask

  task automatic build_program();
    int taken_path [20] = '{184, 188, 196, 200, 204, 212, 220, 224, 232, 240,
                            244, 248, 260, 264, 268, 292, 296, 300, 304, 308};
    u_dmem.mem[64] = 32'h80F1_7F82; // Load source at 0x100
    put(0,   itype(512, 0, 0, 1, OPC_OP_IMM));
    put(4,   utype('h12345, 2, OPC_LUI));
    put(8,   stype(0, 2, 1, 2));
    expect_store(32'h200, 32'h1234_5000, 4'hF);
    put(12,  utype(1, 3, OPC_AUIPC));
    put(16,  stype(4, 3, 1, 2));
    expect_store(32'h204, 32'h0000_100C, 4'hF);
    put(20,  itype(-7, 0, 0, 4, OPC_OP_IMM));
    put(24,  itype(3, 0, 0, 5, OPC_OP_IMM));
    put(28,  rtype(32, 4, 5, 0, 6));      // sub
    put(32,  stype(8, 6, 1, 2));
    expect_store(32'h208, 32'h0000_000A, 4'hF);
    put(36,  rtype(32, 5, 4, 5, 7));      // sra
    put(40,  stype(12, 7, 1, 2));
    expect_store(32'h20C, 32'hFFFF_FFFF, 4'hF);
    put(44,  rtype(0, 5, 4, 5, 8));       // srl
    put(48,  stype(16, 8, 1, 2));
    expect_store(32'h210, 32'h1FFF_FFFF, 4'hF);
    put(52,  rtype(0, 5, 4, 2, 9));       // slt
    put(56,  rtype(0, 5, 4, 3, 10));      // sltu
    put(60,  stype(20, 9, 1, 2));
    expect_store(32'h214, 32'h0000_0001, 4'hF);
    put(64,  stype(24, 10, 1, 2));
    expect_store(32'h218, 32'h0000_0000, 4'hF);
    put(68,  itype('hF0, 4, 4, 11, OPC_OP_IMM));
    put(72,  stype(28, 11, 1, 2));
    expect_store(32'h21C, 32'hFFFF_FF09, 4'hF);
    put(76,  itype(4, 5, 1, 12, OPC_OP_IMM));
    put(80,  rtype(0, 6, 12, 6, 12));     // or
    put(84,  itype('h1B, 12, 7, 12, OPC_OP_IMM));
    put(88,  itype('h401, 4, 5, 13, OPC_OP_IMM)); // srai
    put(92,  rtype(0, 13, 12, 0, 12));
    put(96,  stype(32, 12, 1, 2));
    expect_store(32'h220, 32'h0000_0016, 4'hF);
    put(100, itype(256, 0, 0, 14, OPC_OP_IMM));
    put(104, itype(0, 14, 0, 15, OPC_LOAD));
    put(108, stype(36, 15, 1, 2));
    expect_store(32'h224, 32'hFFFF_FF82, 4'hF);
    put(112, itype(2, 14, 4, 15, OPC_LOAD));
    put(116, stype(40, 15, 1, 2));
    expect_store(32'h228, 32'h0000_00F1, 4'hF);
    put(120, itype(2, 14, 1, 15, OPC_LOAD));
    put(124, stype(44, 15, 1, 2));
    expect_store(32'h22C, 32'hFFFF_80F1, 4'hF);
    put(128, itype(0, 14, 5, 15, OPC_LOAD));
    put(132, stype(48, 15, 1, 2));
    expect_store(32'h230, 32'h0000_7F82, 4'hF);
    put(136, itype(0, 14, 2, 15, OPC_LOAD));
    put(140, stype(52, 15, 1, 2));
    expect_store(32'h234, 32'h80F1_7F82, 4'hF);
    put(144, stype(64, 15, 1, 0));
    expect_store(32'h240, 32'h0000_0082, 4'h1);
    put(148, stype(65, 15, 1, 0));
    expect_store(32'h241, 32'h0000_8200, 4'h2);
    put(152, stype(66, 15, 1, 0));
    expect_store(32'h242, 32'h0082_0000, 4'h4);
    put(156, stype(67, 15, 1, 0));
    expect_store(32'h243, 32'h8200_0000, 4'h8);
    put(160, stype(68, 15, 1, 1));
    expect_store(32'h244, 32'h0000_7F82, 4'h3);
    put(164, stype(70, 15, 1, 1));
    expect_store(32'h246, 32'h7F82_0000, 4'hC);
    put(168, itype(64, 1, 2, 17, OPC_LOAD));
    put(172, stype(72, 17, 1, 2));
    expect_store(32'h248, 32'h8282_8282, 4'hF);
    put(176, btype(8, 5, 5, 0));          // Taken
    put(184, btype(8, 5, 5, 1));
    put(188, btype(8, 5, 4, 4));          // Taken
    put(196, btype(8, 5, 4, 5));
    put(200, btype(8, 5, 4, 6));
    put(204, btype(8, 5, 4, 7));          // Taken
    put(212, btype(8, 5, 4, 1));          // Taken
    put(220, btype(8, 5, 4, 0));
    put(224, btype(8, 4, 5, 5));          // Taken
    put(232, btype(8, 4, 5, 6));          // Taken
    put(240, btype(8, 4, 5, 4));
    put(244, btype(8, 4, 5, 7));
    put(248, jtype(12, 18));
    put(260, stype(76, 18, 1, 2));
    expect_store(32'h24C, 32'h0000_00FC, 4'hF);
    put(264, itype(288, 0, 0, 19, OPC_OP_IMM));
    put(268, itype(4, 19, 0, 21, OPC_JALR));
    put(292, stype(80, 21, 1, 2));
    expect_store(32'h250, 32'h0000_0110, 4'hF);
    put(296, itype(123, 0, 0, 0, OPC_OP_IMM)); // Write to x0
    put(300, stype(84, 0, 1, 2));
    expect_store(32'h254, 32'h0000_0000, 4'hF);
    put(304, itype(1020, 0, 0, 22, OPC_OP_IMM));
    put(308, stype(0, 5, 22, 2));
    expect_store(MARKER, 32'h0000_0003, 4'hF);
    put(312, jtype(0, 0));
    for (int pc = 0; pc <= 176; pc += 4) begin
      fetch_pc[nfetch] = pc;
      nfetch++;
    end
    foreach (taken_path[i]) begin
      fetch_pc[nfetch] = taken_path[i];
      nfetch++;
    end
  endtask

  task automatic finish_run();
    $display("protocol errors: %0d, value errors: %0d, other errors: %0d",
             proto_errs, value_errs, other_errs);
    if (proto_errs + value_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    anrst       = 1'b0;
    nst         = 0;
    nfetch      = 0;
    sidx        = 0;
    fidx        = 0;
    cycles      = 0;
    proto_errs  = 0;
    value_errs  = 0;
    other_errs  = 0;
    marker_seen = 1'b0;
    #1;
    build_program(); // After the memories fill themselves
    repeat (3) @(posedge clk);
    #1 anrst = 1'b1;
  end

  always @(posedge clk) begin
    if (anrst && f_setup) fidx <= fidx + 1;
    if (anrst && d_wr_done) begin
      sidx <= sidx + 1;
      if (dapb.paddr == MARKER) marker_seen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (marker_seen) begin
      if (sidx != nst || fidx != nfetch) begin
        other_errs++;
        $display("run ended after %0d of %0d stores and %0d of %0d fetches",
                 sidx, nst, fidx, nfetch);
      end
      finish_run();
    end else if (cycles >= MAX_CYCLES) begin
      other_errs++;
      $display("timeout: the program did not reach its final store in %0d cycles", MAX_CYCLES);
      finish_run();
    end
  end

  reset_idle: assert property (@(posedge clk)
    !anrst |-> !iapb.psel && !iapb.penable && !dapb.psel && !dapb.penable)
    else begin
      proto_errs++;
      $display("error at %0t ns: bus active during reset", $time);
    end

  first_fetch: assert property (@(posedge clk)
    $rose(anrst) |-> iapb.paddr == '0 && !iapb.penable && !dapb.psel)
    else begin
      value_errs++;
      $display("error at %0t ns: first fetch paddr %h", $time, $sampled(iapb.paddr));
    end

  i_setup: assert property (@(posedge clk) disable iff (!anrst)
    $rose(iapb.penable) |-> $past(iapb.psel && !iapb.penable))
    else begin
      proto_errs++;
      $display("error at %0t ns: fetch penable without setup", $time);
    end

  i_hold: assert property (@(posedge clk) disable iff (!anrst)
    iapb.psel && !(iapb.penable && irsp.pready) |=> iapb.psel && iapb.penable
      && $stable(iapb.paddr) && $stable(iapb.pwrite) && $stable(iapb.pwdata)
      && $stable(iapb.pstrb))
    else begin
      proto_errs++;
      $display("error at %0t ns: fetch transfer changed before pready", $time);
    end

  i_no_write: assert property (@(posedge clk) !iapb.pwrite && iapb.pstrb == '0)
    else begin
      proto_errs++;
      $display("error at %0t ns: write or strobe on the fetch port", $time);
    end

  d_setup: assert property (@(posedge clk) disable iff (!anrst)
    $rose(dapb.penable) |-> $past(dapb.psel && !dapb.penable))
    else begin
      proto_errs++;
      $display("error at %0t ns: data penable without setup", $time);
    end

  d_hold: assert property (@(posedge clk) disable iff (!anrst)
    dapb.psel && !(dapb.penable && drsp.pready) |=> dapb.psel && dapb.penable
      && $stable(dapb.paddr) && $stable(dapb.pwrite) && $stable(dapb.pwdata)
      && $stable(dapb.pstrb))
    else begin
      proto_errs++;
      $display("error at %0t ns: data transfer changed before pready", $time);
    end

  fetch_order: assert property (@(posedge clk) disable iff (!anrst)
    f_setup |-> fidx < nfetch && iapb.paddr == fetch_pc[fidx])
    else begin
      value_errs++;
      $display("error at %0t ns: fetch %0d at %h, expected %h", $time, $sampled(fidx),
               $sampled(iapb.paddr), fetch_pc[$sampled(fidx)]);
    end

  store_match: assert property (@(posedge clk) disable iff (!anrst)
    d_wr_done |-> sidx < nst && dapb.paddr == st_addr[sidx] && dapb.pstrb == st_strb[sidx]
      && (dapb.pwdata & st_mask[sidx]) == st_data[sidx])
    else begin
      value_errs++;
      $display("error at %0t ns: store %0d got %h %h %h, expected %h %h %h", $time,
               $sampled(sidx), $sampled(dapb.paddr), $sampled(dapb.pwdata),
               $sampled(dapb.pstrb), st_addr[$sampled(sidx)], st_data[$sampled(sidx)],
               st_strb[$sampled(sidx)]);
    end

endmodule

//--- verilog/ladybird_alu.sv
module ladybird_alu (
  input  ladybird_pkg::alu_op_t i_op,
  input  logic                  i_alt,
  input  ladybird_pkg::word_t   i_src1,
  input  ladybird_pkg::word_t   i_src2,
  output ladybird_pkg::word_t   o_res
);
  import ladybird_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = i_src2[4:0];
  assign lt_signed   = $signed(i_src1) < $signed(i_src2);
  assign lt_unsigned = i_src1 < i_src2;

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        if (i_alt) begin
          o_res = i_src1 - i_src2;
        end else begin
          o_res = i_src1 + i_src2;
        end
      end
      ALU_SLL:  o_res = i_src1 << shamt;
      ALU_SLT:  o_res = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: o_res = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  o_res = i_src1 ^ i_src2;
      ALU_SR: begin
        if (i_alt) begin
          o_res = $signed(i_src1) >>> shamt; // SRA
        end else begin
          o_res = i_src1 >> shamt;
        end
      end
      ALU_OR:   o_res = i_src1 | i_src2;
      ALU_AND:  o_res = i_src1 & i_src2;
      default:  o_res = '0;
    endcase
  end

endmodule

//--- verilog/ladybird_core.sv
module ladybird_core (
  input  logic                   clk,
  input  logic                   anrst,
  output ladybird_pkg::apb_req_t o_iapb,
  input  ladybird_pkg::apb_rsp_t i_iapb,
  output ladybird_pkg::mem_req_t o_mem_req,
  input  logic                   i_mem_done,
  input  ladybird_pkg::word_t    i_mem_rdata
);
  import ladybird_pkg::*;

  core_state_e state, state_n;
  word_t       pc, pc_n, pc_plus4;
  word_t       inst;
  word_t       regs [32];
  word_t       rs1_val, rs2_val;
  word_t       src1, src2;
  word_t       alu_res, alu_res_l;
  word_t       rd_data;
  reg_addr_t   rs1_addr, rs2_addr;
  decode_t     dec;
  logic        mem_op;
  logic        taken;

  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign mem_op   = dec.is_load | dec.is_store;
  assign pc_plus4 = pc + 32'd4;

  ladybird_decode u_decode (
    .i_inst (inst),
    .o_dec  (dec)
  );

  always_comb begin
    case (dec.src1_sel)
      SRC1_PC:   src1 = pc;
      SRC1_ZERO: src1 = '0;
      default:   src1 = rs1_val;
    endcase
    src2 = dec.src2_imm ? dec.imm : rs2_val;
  end

  ladybird_alu u_alu (
    .i_op   (dec.alu_op),
    .i_alt  (dec.alu_alt),
    .i_src1 (src1),
    .i_src2 (src2),
    .o_res  (alu_res)
  );

  // Fetch master holds pc for the whole transfer
  always_comb begin
    o_iapb         = '0;
    o_iapb.paddr   = pc;
    o_iapb.psel    = anrst && ((state == FETCH_SETUP) || (state == FETCH_ACCESS)); // Idle in reset
    o_iapb.penable = (state == FETCH_ACCESS);
  end

  // Issued in EXEC so the LSU is in SETUP when MEMORY starts
  always_comb begin
    o_mem_req.valid  = (state == EXEC) && mem_op;
    o_mem_req.we     = dec.is_store;
    o_mem_req.funct3 = dec.funct3;
    o_mem_req.addr   = alu_res;
    o_mem_req.wdata  = rs2_val;
  end

  always_comb begin
    case (dec.funct3)
      F3_BEQ:          taken = (alu_res_l == '0);
      F3_BNE:          taken = (alu_res_l != '0);
      F3_BLT, F3_BLTU: taken = alu_res_l[0];
      F3_BGE, F3_BGEU: taken = !alu_res_l[0];
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.is_jump) begin
      pc_n = {alu_res_l[XLEN-1:1], 1'b0};
    end else if (dec.is_branch && taken) begin
      pc_n = pc + dec.imm;
    end else begin
      pc_n = pc_plus4;
    end
    if (dec.is_load) begin
      rd_data = i_mem_rdata;
    end else if (dec.is_jump) begin
      rd_data = pc_plus4; // Link value
    end else begin
      rd_data = alu_res_l;
    end
  end

  always_comb begin
    state_n = state;
    case (state)
      FETCH_SETUP:  state_n = FETCH_ACCESS;
      FETCH_ACCESS: if (i_iapb.pready) state_n = DECODE;
      DECODE:       state_n = EXEC;
      EXEC:         state_n = MEMORY;
      MEMORY:       if (!mem_op || i_mem_done) state_n = COMMIT;
      COMMIT:       state_n = FETCH_SETUP;
      default:      state_n = FETCH_SETUP;
    endcase
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      state <= FETCH_SETUP;
      pc    <= '0;
    end else begin
      state <= state_n;
      if (state == COMMIT) begin
        pc <= pc_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == FETCH_ACCESS) && i_iapb.pready) begin
      inst <= i_iapb.prdata;
    end
    if (state == DECODE) begin
      rs1_val <= (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
      rs2_val <= (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    end
    if (state == EXEC) begin
      alu_res_l <= alu_res;
    end
    if ((state == COMMIT) && dec.write_back) begin
      regs[dec.rd] <= rd_data;
    end
  end

endmodule

//--- verilog/ladybird_decode.sv
module ladybird_decode (
  input  ladybird_pkg::word_t   i_inst,
  output ladybird_pkg::decode_t o_dec
);
  import ladybird_pkg::*;

  logic [6:0] opcode;
  funct3_t    funct3;
  logic       writes_rd;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];

  always_comb begin
    o_dec          = '0;
    writes_rd      = 1'b0;
    o_dec.rd       = i_inst[11:7];
    o_dec.funct3   = funct3;
    o_dec.src1_sel = SRC1_REG;
    o_dec.src2_imm = 1'b1;
    o_dec.alu_op   = ALU_ADD;
    o_dec.imm      = {{20{i_inst[31]}}, i_inst[31:20]}; // I-type
    case (opcode)
      OPC_LUI: begin
        o_dec.imm      = {i_inst[31:12], 12'b0};
        o_dec.src1_sel = SRC1_ZERO;
        writes_rd      = 1'b1;
      end
      OPC_AUIPC: begin
        o_dec.imm      = {i_inst[31:12], 12'b0};
        o_dec.src1_sel = SRC1_PC;
        writes_rd      = 1'b1;
      end
      OPC_JAL: begin
        o_dec.imm      = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                          i_inst[30:21], 1'b0};
        o_dec.src1_sel = SRC1_PC; // Target is pc + imm
        o_dec.is_jump  = 1'b1;
        writes_rd      = 1'b1;
      end
      OPC_JALR: begin
        o_dec.is_jump = 1'b1;
        writes_rd     = 1'b1;
      end
      OPC_BRANCH: begin
        o_dec.imm       = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                           i_inst[11:8], 1'b0};
        o_dec.src2_imm  = 1'b0;
        o_dec.is_branch = 1'b1;
        case (funct3)
          F3_BEQ, F3_BNE: o_dec.alu_op = ALU_XOR; // Zero when equal
          F3_BLT, F3_BGE: o_dec.alu_op = ALU_SLT;
          default:        o_dec.alu_op = ALU_SLTU;
        endcase
      end
      OPC_LOAD: begin
        o_dec.is_load = 1'b1;
        writes_rd     = 1'b1;
      end
      OPC_STORE: begin
        o_dec.imm      = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        o_dec.is_store = 1'b1;
      end
      OPC_OP_IMM: begin
        o_dec.alu_op  = funct3;
        o_dec.alu_alt = (funct3 == ALU_SR) & i_inst[30]; // Bit 30 is plain imm outside SRAI
        writes_rd     = 1'b1;
      end
      OPC_OP: begin
        o_dec.src2_imm = 1'b0;
        o_dec.alu_op   = funct3;
        o_dec.alu_alt  = i_inst[30];
        writes_rd      = 1'b1;
      end
      default: begin
        writes_rd = 1'b0;
      end
    endcase
    o_dec.write_back = writes_rd && (i_inst[11:7] != 5'd0); // x0 stays zero
  end

endmodule

//--- verilog/ladybird_lsu.sv
module ladybird_lsu (
  input  logic                   clk,
  input  logic                   anrst,
  input  ladybird_pkg::mem_req_t i_req,
  output logic                   o_done,
  output ladybird_pkg::word_t    o_rdata,
  output ladybird_pkg::apb_req_t o_dapb,
  input  ladybird_pkg::apb_rsp_t i_dapb
);
  import ladybird_pkg::*;

  lsu_state_e state, state_n;
  word_t      addr_l;
  word_t      wdata_l;
  logic       we_l;
  funct3_t    funct3_l;
  logic [3:0] strb_l;
  word_t      wdata_al;
  logic [3:0] strb_al;
  word_t      lane;
  word_t      load_ext;

  // Store data copied into every lane for the strobe to pick from
  always_comb begin
    case (i_req.funct3)
      F3_BYTE: begin
        wdata_al = {4{i_req.wdata[7:0]}};
        strb_al  = 4'b0001 << i_req.addr[1:0];
      end
      F3_HALF: begin
        wdata_al = {2{i_req.wdata[15:0]}};
        strb_al  = 4'b0011 << {i_req.addr[1], 1'b0};
      end
      default: begin
        wdata_al = i_req.wdata;
        strb_al  = 4'b1111;
      end
    endcase
    if (!i_req.we) begin
      strb_al = '0; // Reads carry no strobe
    end
  end

  always_comb begin
    lane = i_dapb.prdata >> {addr_l[1:0], 3'b000};
    case (funct3_l)
      F3_BYTE:  load_ext = {{24{lane[7]}}, lane[7:0]};
      F3_BYTEU: load_ext = {24'b0, lane[7:0]};
      F3_HALF:  load_ext = {{16{lane[15]}}, lane[15:0]};
      F3_HALFU: load_ext = {16'b0, lane[15:0]};
      default:  load_ext = lane;
    endcase
  end

  always_comb begin
    state_n = state;
    case (state)
      IDLE:    if (i_req.valid) state_n = SETUP;
      SETUP:   state_n = ACCESS;
      ACCESS:  if (i_dapb.pready) state_n = DONE;
      DONE:    state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      state <= IDLE;
    end else begin
      state <= state_n;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == IDLE) && i_req.valid) begin
      addr_l   <= i_req.addr;
      we_l     <= i_req.we;
      funct3_l <= i_req.funct3;
      wdata_l  <= wdata_al;
      strb_l   <= strb_al;
    end
    if ((state == ACCESS) && i_dapb.pready && !we_l) begin
      o_rdata <= load_ext;
    end
  end

  always_comb begin
    o_dapb.paddr   = addr_l;
    o_dapb.psel    = (state == SETUP) || (state == ACCESS);
    o_dapb.penable = (state == ACCESS);
    o_dapb.pwrite  = we_l;
    o_dapb.pwdata  = wdata_l;
    o_dapb.pstrb   = strb_l;
  end

  assign o_done = (state == DONE);

endmodule

//--- verilog/ladybird_pkg.sv
package ladybird_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [2:0]      alu_op_t;

  // Same encoding as funct3 of OP and OP-IMM
  localparam alu_op_t ALU_ADD  = 3'b000;
  localparam alu_op_t ALU_SLL  = 3'b001;
  localparam alu_op_t ALU_SLT  = 3'b010;
  localparam alu_op_t ALU_SLTU = 3'b011;
  localparam alu_op_t ALU_XOR  = 3'b100;
  localparam alu_op_t ALU_SR   = 3'b101;
  localparam alu_op_t ALU_OR   = 3'b110;
  localparam alu_op_t ALU_AND  = 3'b111;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam funct3_t F3_BYTE  = 3'b000;
  localparam funct3_t F3_HALF  = 3'b001;
  localparam funct3_t F3_BYTEU = 3'b100;
  localparam funct3_t F3_HALFU = 3'b101;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam logic [1:0] SRC1_REG  = 2'd0;
  localparam logic [1:0] SRC1_PC   = 2'd1;
  localparam logic [1:0] SRC1_ZERO = 2'd2;

  typedef struct packed {
    word_t     imm;
    logic [1:0] src1_sel;
    logic      src2_imm;
    alu_op_t   alu_op;
    logic      alu_alt;    // Subtract or arithmetic shift
    logic      write_back;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jump;
    reg_addr_t rd;
    funct3_t   funct3;
  } decode_t;

  typedef struct packed {
    logic    valid;
    logic    we;
    funct3_t funct3;
    word_t   addr;
    word_t   wdata;
  } mem_req_t;

  typedef struct packed {
    word_t      paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    word_t      pwdata;
    logic [3:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
  } apb_rsp_t;

  typedef enum logic [2:0] {
    FETCH_SETUP,
    FETCH_ACCESS,
    DECODE,
    EXEC,
    MEMORY,
    COMMIT
  } core_state_e;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    DONE
  } lsu_state_e;

endpackage

//--- verilog/ladybird_top.sv
module ladybird_top (
  input  logic                   clk,
  input  logic                   anrst,
  output ladybird_pkg::apb_req_t o_iapb,
  input  ladybird_pkg::apb_rsp_t i_iapb,
  output ladybird_pkg::apb_req_t o_dapb,
  input  ladybird_pkg::apb_rsp_t i_dapb
);
  import ladybird_pkg::*;

  mem_req_t mem_req;
  logic     mem_done;
  word_t    mem_rdata;

  ladybird_core u_core (
    .clk         (clk),
    .anrst       (anrst),
    .o_iapb      (o_iapb),
    .i_iapb      (i_iapb),
    .o_mem_req   (mem_req),
    .i_mem_done  (mem_done),
    .i_mem_rdata (mem_rdata)
  );

  ladybird_lsu u_lsu (
    .clk     (clk),
    .anrst   (anrst),
    .i_req   (mem_req),
    .o_done  (mem_done),
    .o_rdata (mem_rdata),
    .o_dapb  (o_dapb),
    .i_dapb  (i_dapb)
  );

endmodule
